// File: src/tcm_pkg.sv
package tcm_pkg;

    // master side bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;    // one strobe per byte lane

    // address map of the two banks
    localparam logic [addr_w-1:0] itcm_base = 32'h0000_0000;
    localparam logic [addr_w-1:0] dtcm_base = 32'h1000_0000;

    localparam int itcm_bytes = 4096;
    localparam int dtcm_bytes = 4096;

    // depth in words follows from size and data width
    localparam int itcm_words = itcm_bytes / strb_w;
    localparam int dtcm_words = dtcm_bytes / strb_w;

    // wide enough for the larger of the two banks
    localparam int word_idx_w = (itcm_words > dtcm_words) ? $clog2(itcm_words)
                                                          : $clog2(dtcm_words);

endpackage

// File: src/tcm_rd_if.sv
`timescale 1ns/10ps

interface tcm_rd_if;
    import tcm_pkg::*;

    logic                  arvalid;
    logic [word_idx_w-1:0] araddr;     // word index inside the bank
    logic                  arready;
    logic [data_w-1:0]     rdata;
    logic                  rvalid;
    logic                  rready;

    // address side driven by the router
    modport req (
        output arvalid,
        output araddr,
        input  arready
    );

    modport bank (
        input  arvalid,
        input  araddr,
        output arready,
        output rdata,
        output rvalid,
        input  rready
    );

    // response side also watches the address handshake
    modport rsp (
        input  arvalid,
        input  arready,
        input  rdata,
        input  rvalid,
        output rready
    );

endinterface

// File: src/tcm_wr_if.sv
`timescale 1ns/10ps

interface tcm_wr_if;
    import tcm_pkg::*;

    // address and data travel together in one handshake
    logic                  wvalid;
    logic [word_idx_w-1:0] waddr;
    logic [data_w-1:0]     wdata;
    logic [strb_w-1:0]     wstrb;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;

    modport req (
        output wvalid,
        output waddr,
        output wdata,
        output wstrb,
        input  wready
    );

    modport bank (
        input  wvalid,
        input  waddr,
        input  wdata,
        input  wstrb,
        output wready,
        output bvalid,
        input  bready
    );

    modport rsp (
        input  bvalid,
        output bready
    );

endinterface

// File: src/tcm_addr_router.sv
`timescale 1ns/10ps

module tcm_addr_router (
    input  logic                        clk,
    input  logic                        rst_n,
    // M0 instruction fetch
    input  logic [tcm_pkg::addr_w-1:0]  m0_araddr,
    input  logic                        m0_arvalid,
    output logic                        m0_arready,
    // M1 read address
    input  logic [tcm_pkg::addr_w-1:0]  m1_araddr,
    input  logic                        m1_arvalid,
    output logic                        m1_arready,
    // M1 write address and data
    input  logic [tcm_pkg::addr_w-1:0]  m1_awaddr,
    input  logic                        m1_awvalid,
    output logic                        m1_awready,
    input  logic [tcm_pkg::data_w-1:0]  m1_wdata,
    input  logic [tcm_pkg::strb_w-1:0]  m1_wstrb,
    input  logic                        m1_wvalid,
    output logic                        m1_wready,
    tcm_rd_if.req                       itcm_rd,
    tcm_rd_if.req                       dtcm_rd,
    tcm_wr_if.req                       itcm_wr,
    tcm_wr_if.req                       dtcm_wr,
    output logic                        itcm_rd_m1
);
    import tcm_pkg::*;

    // true when addr lies in [base, base + bytes)
    function automatic logic in_bank(input logic [addr_w-1:0] addr,
                                     input logic [addr_w-1:0] base,
                                     input int unsigned       bytes);
        logic [addr_w-1:0] off;
        off = addr - base;
        return (addr >= base) && (off < bytes);
    endfunction

    // byte offset to word index with the low two bits dropped
    function automatic logic [word_idx_w-1:0] word_idx(input logic [addr_w-1:0] addr,
                                                       input logic [addr_w-1:0] base);
        logic [addr_w-1:0] off;
        off = addr - base;
        return off[word_idx_w+1:2];
    endfunction

    logic m0_itcm_req;
    logic m1_itcm_rreq;
    logic m1_dtcm_rreq;
    logic m1_wr_both;

    assign m0_itcm_req  = m0_arvalid && in_bank(m0_araddr, itcm_base, itcm_bytes);
    assign m1_itcm_rreq = m1_arvalid && in_bank(m1_araddr, itcm_base, itcm_bytes);
    assign m1_dtcm_rreq = m1_arvalid && in_bank(m1_araddr, dtcm_base, dtcm_bytes);
    assign m1_wr_both   = m1_awvalid && m1_wvalid;   // both halves present

    // M1 always ahead of M0 on the ITCM read port
    assign itcm_rd_m1     = m1_itcm_rreq;
    assign itcm_rd.arvalid = m1_itcm_rreq || m0_itcm_req;
    assign itcm_rd.araddr  = m1_itcm_rreq ? word_idx(m1_araddr, itcm_base)
                                          : word_idx(m0_araddr, itcm_base);

    // DTCM only ever sees M1
    assign dtcm_rd.arvalid = m1_dtcm_rreq;
    assign dtcm_rd.araddr  = word_idx(m1_araddr, dtcm_base);

    assign m0_arready = m0_itcm_req && !m1_itcm_rreq && itcm_rd.arready;
    assign m1_arready = (m1_itcm_rreq && itcm_rd.arready) ||
                        (m1_dtcm_rreq && dtcm_rd.arready);

    // write data fanned to both banks and valid steered by decode
    assign itcm_wr.wvalid = m1_wr_both && in_bank(m1_awaddr, itcm_base, itcm_bytes);
    assign itcm_wr.waddr  = word_idx(m1_awaddr, itcm_base);
    assign itcm_wr.wdata  = m1_wdata;
    assign itcm_wr.wstrb  = m1_wstrb;

    assign dtcm_wr.wvalid = m1_wr_both && in_bank(m1_awaddr, dtcm_base, dtcm_bytes);
    assign dtcm_wr.waddr  = word_idx(m1_awaddr, dtcm_base);
    assign dtcm_wr.wdata  = m1_wdata;
    assign dtcm_wr.wstrb  = m1_wstrb;

    // address and data accepted in the same cycle
    assign m1_awready = (itcm_wr.wvalid && itcm_wr.wready) ||
                        (dtcm_wr.wvalid && dtcm_wr.wready);
    assign m1_wready  = m1_awready;

endmodule

// File: src/tcm_bank.sv
`timescale 1ns/10ps

module tcm_bank #(
    parameter int depth = 1024
) (
    input  logic  clk,
    input  logic  rst_n,
    tcm_rd_if.bank rd,
    tcm_wr_if.bank wr
);
    import tcm_pkg::*;

    logic [data_w-1:0] mem [depth];

    logic              rvalid_q;
    logic [data_w-1:0] rdata_q;
    logic              bvalid_q;
    logic              rd_fire;
    logic              wr_fire;

    // free slot, or the held response leaves this cycle
    assign rd.arready = !rvalid_q || rd.rready;
    assign wr.wready  = !bvalid_q || wr.bready;

    assign rd_fire = rd.arvalid && rd.arready;
    assign wr_fire = wr.wvalid && wr.wready;

    assign rd.rvalid = rvalid_q;
    assign rd.rdata  = rdata_q;
    assign wr.bvalid = bvalid_q;

    // byte lane writes
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < strb_w; i++) begin
                if (wr.wstrb[i]) begin
                    mem[wr.waddr][8*i +: 8] <= wr.wdata[8*i +: 8];
                end
            end
        end
    end

    // read data captured at the address handshake and held until taken
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_q <= mem[rd.araddr];   // old word on same-cycle write
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (rd.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // memory already updated when the write response shows
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
        end else if (wr.bready) begin
            bvalid_q <= 1'b0;
        end
    end

endmodule

// File: src/tcm_rsp_steer.sv
`timescale 1ns/10ps

module tcm_rsp_steer (
    input  logic                        clk,
    input  logic                        rst_n,
    tcm_rd_if.rsp                       itcm_rd,
    tcm_rd_if.rsp                       dtcm_rd,
    tcm_wr_if.rsp                       itcm_wr,
    tcm_wr_if.rsp                       dtcm_wr,
    input  logic                        itcm_rd_m1,
    // M0 read data
    output logic [tcm_pkg::data_w-1:0]  m0_rdata,
    output logic                        m0_rvalid,
    input  logic                        m0_rready,
    // M1 read data
    output logic [tcm_pkg::data_w-1:0]  m1_rdata,
    output logic                        m1_rvalid,
    input  logic                        m1_rready,
    // M1 write response
    output logic                        m1_bvalid,
    input  logic                        m1_bready
);

    logic itcm_owner_m1;   // who gets the ITCM response in flight
    logic itcm_m1_pend;

    // latch the requester on each ITCM address handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            itcm_owner_m1 <= 1'b0;
        end else if (itcm_rd.arvalid && itcm_rd.arready) begin
            itcm_owner_m1 <= itcm_rd_m1;
        end
    end

    assign itcm_m1_pend = itcm_rd.rvalid && itcm_owner_m1;

    // M0 only ever reads ITCM
    assign m0_rvalid = itcm_rd.rvalid && !itcm_owner_m1;
    assign m0_rdata  = itcm_rd.rdata;

    // M1 takes ITCM first if both banks hold something for it
    assign m1_rvalid = itcm_m1_pend || dtcm_rd.rvalid;
    assign m1_rdata  = itcm_m1_pend ? itcm_rd.rdata : dtcm_rd.rdata;

    assign itcm_rd.rready = itcm_owner_m1 ? m1_rready : m0_rready;
    assign dtcm_rd.rready = m1_rready && !itcm_m1_pend;

    // write responses merged with ITCM first
    assign m1_bvalid      = itcm_wr.bvalid || dtcm_wr.bvalid;
    assign itcm_wr.bready = m1_bready;
    assign dtcm_wr.bready = m1_bready && !itcm_wr.bvalid;

endmodule

// File: src/tcm_subsystem.sv
`timescale 1ns/10ps

module tcm_subsystem (
    input  logic                        clk,
    input  logic                        rst_n,
    // M0 fetch port with ITCM reads only
    input  logic [tcm_pkg::addr_w-1:0]  m0_araddr,
    input  logic                        m0_arvalid,
    output logic                        m0_arready,
    output logic [tcm_pkg::data_w-1:0]  m0_rdata,
    output logic                        m0_rvalid,
    input  logic                        m0_rready,
    // M1 read
    input  logic [tcm_pkg::addr_w-1:0]  m1_araddr,
    input  logic                        m1_arvalid,
    output logic                        m1_arready,
    output logic [tcm_pkg::data_w-1:0]  m1_rdata,
    output logic                        m1_rvalid,
    input  logic                        m1_rready,
    // M1 write
    input  logic [tcm_pkg::addr_w-1:0]  m1_awaddr,
    input  logic                        m1_awvalid,
    output logic                        m1_awready,
    input  logic [tcm_pkg::data_w-1:0]  m1_wdata,
    input  logic [tcm_pkg::strb_w-1:0]  m1_wstrb,
    input  logic                        m1_wvalid,
    output logic                        m1_wready,
    output logic                        m1_bvalid,
    input  logic                        m1_bready
);
    import tcm_pkg::*;

    tcm_rd_if itcm_rd ();
    tcm_rd_if dtcm_rd ();
    tcm_wr_if itcm_wr ();
    tcm_wr_if dtcm_wr ();

    logic itcm_rd_m1;   // current ITCM read request is from M1

    // decode and arbitration are purely combinational
    tcm_addr_router router0 (
        .clk        (),
        .rst_n      (),
        .m0_araddr  (m0_araddr),
        .m0_arvalid (m0_arvalid),
        .m0_arready (m0_arready),
        .m1_araddr  (m1_araddr),
        .m1_arvalid (m1_arvalid),
        .m1_arready (m1_arready),
        .m1_awaddr  (m1_awaddr),
        .m1_awvalid (m1_awvalid),
        .m1_awready (m1_awready),
        .m1_wdata   (m1_wdata),
        .m1_wstrb   (m1_wstrb),
        .m1_wvalid  (m1_wvalid),
        .m1_wready  (m1_wready),
        .itcm_rd    (itcm_rd),
        .dtcm_rd    (dtcm_rd),
        .itcm_wr    (itcm_wr),
        .dtcm_wr    (dtcm_wr),
        .itcm_rd_m1 (itcm_rd_m1)
    );

    tcm_bank #(
        .depth (itcm_words)
    ) itcm0 (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (itcm_rd),
        .wr    (itcm_wr)
    );

    tcm_bank #(
        .depth (dtcm_words)
    ) dtcm0 (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (dtcm_rd),
        .wr    (dtcm_wr)
    );

    tcm_rsp_steer steer0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .itcm_rd    (itcm_rd),
        .dtcm_rd    (dtcm_rd),
        .itcm_wr    (itcm_wr),
        .dtcm_wr    (dtcm_wr),
        .itcm_rd_m1 (itcm_rd_m1),
        .m0_rdata   (m0_rdata),
        .m0_rvalid  (m0_rvalid),
        .m0_rready  (m0_rready),
        .m1_rdata   (m1_rdata),
        .m1_rvalid  (m1_rvalid),
        .m1_rready  (m1_rready),
        .m1_bvalid  (m1_bvalid),
        .m1_bready  (m1_bready)
    );

endmodule

// File: verification/tcm_subsystem_asserts.sv
`timescale 1ns/10ps

module tcm_subsystem_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic [tcm_pkg::addr_w-1:0]  m0_araddr,
    input logic                        m0_arready,
    input logic [tcm_pkg::data_w-1:0]  m0_rdata,
    input logic                        m0_rvalid,
    input logic                        m0_rready,
    input logic [tcm_pkg::data_w-1:0]  m1_rdata,
    input logic                        m1_rvalid,
    input logic                        m1_rready,
    input logic                        m1_bvalid,
    input logic                        m1_bready,
    input logic                        m1_awready,
    input logic                        m1_wready
);
    import tcm_pkg::*;

    int fail_count = 0;

    // responses hold with their data until taken
    m0_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m0_rvalid && !m0_rready |=> m0_rvalid && $stable(m0_rdata))
        else begin
            fail_count++;
            $error("m0 read response dropped or changed before m0_rready");
        end
    m1_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m1_rvalid && !m1_rready |=> m1_rvalid && $stable(m1_rdata))
        else begin
            fail_count++;
            $error("m1 read response dropped or changed before m1_rready");
        end
    m1_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m1_bvalid && !m1_bready |=> m1_bvalid)
        else begin
            fail_count++;
            $error("m1_bvalid dropped before m1_bready");
        end

    m0_ar_in_itcm: assert property (@(posedge clk) disable iff (!rst_n)
        m0_arready |-> (m0_araddr >= itcm_base) && (m0_araddr - itcm_base < itcm_bytes))
        else begin
            fail_count++;
            $error("m0_arready for an address outside ITCM");
        end
    aw_w_equal: assert property (@(posedge clk) disable iff (!rst_n)
        m1_awready == m1_wready)
        else begin
            fail_count++;
            $error("m1_awready and m1_wready differ");
        end

endmodule

bind tcm_subsystem tcm_subsystem_asserts asr0 (.*);

// File: verification/tcm_checker.sv
`timescale 1ns/10ps

module tcm_checker (
    input logic                        clk,
    input logic                        rst_n,
    input logic [tcm_pkg::addr_w-1:0]  m0_araddr,
    input logic                        m0_arvalid,
    input logic                        m0_arready,
    input logic [tcm_pkg::data_w-1:0]  m0_rdata,
    input logic                        m0_rvalid,
    input logic                        m0_rready,
    input logic [tcm_pkg::addr_w-1:0]  m1_araddr,
    input logic                        m1_arvalid,
    input logic                        m1_arready,
    input logic [tcm_pkg::data_w-1:0]  m1_rdata,
    input logic                        m1_rvalid,
    input logic                        m1_rready,
    input logic [tcm_pkg::addr_w-1:0]  m1_awaddr,
    input logic                        m1_awvalid,
    input logic                        m1_awready,
    input logic [tcm_pkg::data_w-1:0]  m1_wdata,
    input logic [tcm_pkg::strb_w-1:0]  m1_wstrb,
    input logic                        m1_bvalid,
    input logic                        m1_bready
);
    import tcm_pkg::*;

    logic [7:0]        bytes_model [logic [31:0]];   // keyed by byte address
    logic [data_w-1:0] m0_exp [$];
    logic [data_w-1:0] m1_exp [$];
    int                writes_open = 0;
    int                errors = 0;
    int                checks = 0;
    int                errors_at_start = 0;

    function automatic logic [data_w-1:0] model_word(input logic [addr_w-1:0] addr);
        logic [data_w-1:0] w;
        for (int i = 0; i < strb_w; i++) begin
            w[8*i +: 8] = bytes_model.exists(addr + i) ? bytes_model[addr + i] : 8'hxx;
        end
        return w;
    endfunction

    function automatic logic is_itcm(input logic [addr_w-1:0] addr);
        return (addr >= itcm_base) && (addr - itcm_base < itcm_bytes);
    endfunction

    task automatic compare(input string who, input logic [data_w-1:0] got,
                           input logic [data_w-1:0] q [$]);
        logic [data_w-1:0] exp;
        checks++;
        if (q.size() == 0) begin
            errors++;
            $display("%s returned a read response that nobody asked for", who);
        end else begin
            exp = q[0];
            if (got !== exp) begin
                errors++;
                $display("ERROR %0t ns: %s read data %h, expected %h", $time, who, got, exp);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (m0_rvalid && m0_rready) begin
                compare("m0", m0_rdata, m0_exp);
                if (m0_exp.size() > 0) void'(m0_exp.pop_front());
            end
            if (m1_rvalid && m1_rready) begin
                compare("m1", m1_rdata, m1_exp);
                if (m1_exp.size() > 0) void'(m1_exp.pop_front());
            end
            if (m1_bvalid && m1_bready) begin
                if (writes_open == 0) begin
                    errors++;
                    $display("m1 write response without an open write at %0t ns", $time);
                end else begin
                    writes_open--;
                end
            end
            // M0 never wins while M1 asks for ITCM
            if (m0_arvalid && m0_arready && m1_arvalid && is_itcm(m1_araddr)) begin
                errors++;
                $display("ERROR %0t ns: m0 granted ITCM while m1 requested it", $time);
            end
            // reads see memory before a write in the same cycle
            if (m0_arvalid && m0_arready) m0_exp.push_back(model_word(m0_araddr));
            if (m1_arvalid && m1_arready) m1_exp.push_back(model_word(m1_araddr));
            if (m1_awvalid && m1_awready) begin
                writes_open++;
                for (int i = 0; i < strb_w; i++) begin
                    if (m1_wstrb[i]) bytes_model[m1_awaddr + i] = m1_wdata[8*i +: 8];
                end
            end
        end
    end

    task automatic check_idle();
        checks++;
        if (m0_rvalid || m1_rvalid || m1_bvalid) begin
            errors++;
            $display("ERROR %0t ns: response valid high after reset", $time);
        end
    endtask

    task automatic report_test(input int id);
        $display("test %0d: %s (%0d errors)", id,
                 (errors == errors_at_start) ? "ok" : "FAILED", errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic report_counts(input int assert_fails);
        if (m0_exp.size() + m1_exp.size() + writes_open != 0) begin
            errors++;
            $display("responses still missing at the end of the run");
        end
        if (assert_fails != 0) begin
            errors += assert_fails;
            $display("%0d assertion failures on the DUT ports", assert_fails);
        end
        $display("checks %0d, errors %0d", checks, errors);
    endtask

endmodule

// File: verification/tb_tcm_subsystem.sv
`timescale 1ns/10ps

module tb_tcm_subsystem;
    import tcm_pkg::*;

    typedef struct {
        int                test_id;
        int                phase;    // entries of one phase run on both masters together
        int                master;
        logic              wr;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              bp;       // random back-pressure on the response
    } entry_t;

    logic              clk;
    logic              rst_n;
    logic [addr_w-1:0] m0_araddr, m1_araddr, m1_awaddr;
    logic              m0_arvalid, m0_arready, m0_rvalid, m0_rready;
    logic              m1_arvalid, m1_arready, m1_rvalid, m1_rready;
    logic [data_w-1:0] m0_rdata, m1_rdata, m1_wdata;
    logic [strb_w-1:0] m1_wstrb;
    logic              m1_awvalid, m1_awready, m1_wvalid, m1_wready, m1_bvalid, m1_bready;
    entry_t            table_q [$];
    int                last_phase;

    tcm_subsystem dut0 (.*);
    tcm_checker   chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add(input int id, input int ph, input int m, input logic wr,
                       input logic [addr_w-1:0] a, input logic [data_w-1:0] d,
                       input logic [strb_w-1:0] s, input logic bp);
        entry_t e;
        e = '{id, ph, m, wr, a, d, s, bp};
        table_q.push_back(e);
    endtask

    task automatic run_entry(input entry_t e);
        logic hs;
        @(negedge clk);
        if (e.master == 0) begin
            m0_araddr = e.addr;
            m0_arvalid = 1'b1;
        end else if (e.wr) begin
            {m1_awaddr, m1_wdata, m1_wstrb} = {e.addr, e.data, e.strb};
            {m1_awvalid, m1_wvalid} = 2'b11;
        end else begin
            m1_araddr = e.addr;
            m1_arvalid = 1'b1;
        end
        forever begin
            #1 hs = (e.master == 0) ? m0_arready : (e.wr ? m1_awready : m1_arready);
            @(posedge clk);
            if (hs) break;
            @(negedge clk);
        end
        forever begin
            @(negedge clk);
            if (e.master == 0) m0_arvalid = 1'b0;
            else {m1_awvalid, m1_wvalid, m1_arvalid} = 3'b000;
            hs = !e.bp || ($urandom % 3 != 0);
            if (e.master == 0) m0_rready = hs;
            else if (e.wr) m1_bready = hs;
            else m1_rready = hs;
            #1 hs = (e.master == 0) ? (m0_rvalid && m0_rready) :
                    (e.wr ? (m1_bvalid && m1_bready) : (m1_rvalid && m1_rready));
            @(posedge clk);
            if (hs) break;
        end
        @(negedge clk);
        if (e.master == 0) m0_rready = 1'b0;
        else {m1_rready, m1_bready} = 2'b00;
        repeat ($urandom % 3) @(negedge clk);   // idle gap
    endtask

    task automatic run_master(input int m, input int ph);
        foreach (table_q[i]) begin
            if (table_q[i].phase == ph && table_q[i].master == m) run_entry(table_q[i]);
        end
    endtask

    initial begin
        void'($urandom(32'hfd79aabb));
        rst_n = 1'b0;
        {m0_araddr, m1_araddr, m1_awaddr, m1_wdata, m1_wstrb} = '0;
        {m0_arvalid, m0_rready, m1_arvalid, m1_rready} = '0;
        {m1_awvalid, m1_wvalid, m1_bready} = '0;
        add(1, 0, 1, 1, 32'h1000_0000, 32'hdead_beef, 4'hf, 0);
        add(1, 0, 1, 1, 32'h1000_0004, 32'h0123_4567, 4'hf, 0);
        add(1, 0, 1, 1, 32'h1000_0ffc, 32'hcafe_f00d, 4'hf, 0);
        add(1, 0, 1, 0, 32'h1000_0000, 0, 0, 0);
        add(1, 0, 1, 0, 32'h1000_0004, 0, 0, 0);
        add(1, 0, 1, 0, 32'h1000_0ffc, 0, 0, 0);
        add(2, 1, 1, 1, 32'h0000_0040, 32'h1122_3344, 4'hf, 0);
        add(2, 1, 1, 1, 32'h0000_0040, 32'haabb_ccdd, 4'h5, 0);
        add(2, 2, 0, 0, 32'h0000_0040, 0, 0, 0);
        add(3, 3, 1, 1, 32'h0000_0080, 32'h8080_8080, 4'hf, 0);
        add(3, 3, 1, 1, 32'h0000_0084, 32'h8484_8484, 4'hf, 0);
        add(3, 4, 0, 0, 32'h0000_0080, 0, 0, 0);
        add(3, 4, 1, 0, 32'h0000_0084, 0, 0, 0);
        add(4, 5, 1, 0, 32'h0000_0040, 0, 0, 1);
        add(4, 5, 1, 0, 32'h0000_0084, 0, 0, 1);
        add(4, 5, 1, 0, 32'h1000_0004, 0, 0, 1);
        add(4, 5, 0, 0, 32'h0000_0080, 0, 0, 1);
        add(4, 5, 0, 0, 32'h0000_0040, 0, 0, 1);
        add(4, 5, 0, 0, 32'h0000_0084, 0, 0, 1);
        add(5, 6, 1, 1, 32'h1000_0008, 32'h5555_aaaa, 4'hf, 1);
        add(5, 6, 1, 1, 32'h0000_0088, 32'h7777_1111, 4'hf, 1);
        add(5, 6, 1, 1, 32'h1000_000c, 32'h0f0f_f0f0, 4'hf, 1);
        add(5, 6, 1, 0, 32'h1000_0008, 0, 0, 0);
        add(5, 6, 1, 0, 32'h1000_000c, 0, 0, 0);
        add(5, 7, 0, 0, 32'h0000_0088, 0, 0, 0);
        last_phase = 7;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        chk0.check_idle();
        chk0.report_test(6);
        for (int ph = 0; ph <= last_phase; ph++) begin
            fork
                run_master(0, ph);
                run_master(1, ph);
            join
            foreach (table_q[i]) begin
                // report once the last phase of a test is done
                if (table_q[i].phase == ph &&
                    (ph == last_phase || table_q[i].test_id != test_of_phase(ph + 1))) begin
                    chk0.report_test(table_q[i].test_id);
                    break;
                end
            end
        end
        repeat (4) @(posedge clk);
        chk0.report_counts(dut0.asr0.fail_count);
        if (chk0.errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    function automatic int test_of_phase(input int ph);
        foreach (table_q[i]) begin
            if (table_q[i].phase == ph) return table_q[i].test_id;
        end
        return -1;
    endfunction

    // watchdog sized from the table length
    initial begin
        @(posedge rst_n);
        repeat (table_q.size() * 40) @(posedge clk);
        $display("run timed out waiting for a handshake or response");
        $display("Test failed");
        $finish;
    end

endmodule

// File: verilog.f
src/tcm_pkg.sv
src/tcm_rd_if.sv
src/tcm_wr_if.sv
src/tcm_addr_router.sv
src/tcm_bank.sv
src/tcm_rsp_steer.sv
src/tcm_subsystem.sv
verification/tcm_subsystem_asserts.sv
verification/tcm_checker.sv
verification/tb_tcm_subsystem.sv
